// File: source/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path width in bits.
`define CORE_XLEN 32

// RV32E register count.
`define CORE_REG_COUNT 16

// First fetch address.
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: source/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b  // LUI.
    } alu_op_e;

    typedef enum logic [1:0] {
        ctrl_plain,
        ctrl_branch,
        ctrl_jal,
        ctrl_jalr
    } ctrl_kind_e;

    typedef struct packed {
        word_t      pc;
        word_t      inst;
        word_t      operand_a;     // Already muxed.
        word_t      operand_b;     // Already muxed.
        word_t      rs1_value;
        word_t      rs2_value;
        word_t      imm;
        reg_idx_t   rd;
        logic       rd_we;
        alu_op_e    alu_op;
        ctrl_kind_e ctrl_kind;
        logic [2:0] branch_funct;
        logic       illegal;
    } decoded_t;

    typedef struct packed {
        word_t    pc;
        word_t    inst;
        word_t    result;
        reg_idx_t rd;
        logic     rd_we;
        logic     taken;  // Set for jumps too.
        word_t    target;
        logic     illegal;
    } exec_t;

    typedef struct packed {
        word_t    pc;
        word_t    inst;
        reg_idx_t rd;
        logic     rd_we;
        word_t    rd_value;
        word_t    next_pc;
        logic     illegal;
    } commit_t;

endpackage

// File: source/fetch_unit.sv
`include "core_cfg.svh"

module fetch_unit (
    input  logic        clock,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic [31:0] inst_data,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output logic        inst_req,
    output logic [31:0] inst_addr,
    output logic        fetch_valid,
    output logic [31:0] fetch_pc,
    output logic [31:0] fetch_inst
);
    import core_pkg::*;

    typedef enum logic {
        st_wait_reply,
        st_wait_redirect
    } fetch_state_e;

    fetch_state_e state_q;
    word_t        pc_q;
    logic         booted_q;  // Low only in the first cycle out of reset.
    logic         req_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q  <= st_wait_redirect;
            booted_q <= 1'b0;
            req_q    <= 1'b0;
            pc_q     <= `CORE_RESET_PC;
        end else begin
            booted_q <= 1'b1;
            req_q    <= !booted_q || redirect_valid;  // One-cycle request pulse.
            if (!booted_q) begin
                state_q <= st_wait_reply;
            end else if (redirect_valid) begin
                state_q <= st_wait_reply;
                pc_q    <= redirect_pc;
            end else if (inst_valid && state_q == st_wait_reply) begin
                state_q <= st_wait_redirect;
            end
        end
    end

    assign inst_req    = req_q;
    assign inst_addr   = pc_q;    // Held until the reply.
    assign fetch_valid = inst_valid && state_q == st_wait_reply;
    assign fetch_pc    = pc_q;
    assign fetch_inst  = inst_data;

    // Memory replies at least one cycle after the request pulse.
    reply_needs_request: assert property (@(posedge clock) disable iff (reset)
        inst_valid |-> state_q == st_wait_reply && !req_q);

    // Result stage redirects only once the reply has gone down the pipe.
    redirect_after_reply: assert property (@(posedge clock) disable iff (reset)
        redirect_valid |-> state_q == st_wait_redirect);

endmodule

// File: source/register_file.sv
`include "core_cfg.svh"

module register_file (
    input  logic        clock,
    input  logic        reset,
    input  logic [3:0]  rs1_addr,
    input  logic [3:0]  rs2_addr,
    input  logic        write_en,
    input  logic [3:0]  write_addr,
    input  logic [31:0] write_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);
    import core_pkg::*;

    word_t regs [`CORE_REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // x0 is wired to zero.
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Result stage filters rd == 0 before driving the port.
    no_write_to_x0: assert property (@(posedge clock) disable iff (reset)
        write_en |-> write_addr != '0);

endmodule

// File: source/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            out_data <= in_data;  // Held between records.
        end
    end

endmodule

// File: source/decode_unit.sv
module decode_unit (
    input  logic [31:0]        fetch_pc,
    input  logic [31:0]        fetch_inst,
    input  logic [31:0]        rs1_data,
    input  logic [31:0]        rs2_data,
    output logic [3:0]         rs1_addr,
    output logic [3:0]         rs2_addr,
    output core_pkg::decoded_t decoded
);
    import core_pkg::*;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    logic       known;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       uses_rd;
    logic       bad_reg;
    logic       illegal;
    alu_op_e    alu_op;
    ctrl_kind_e ctrl_kind;
    word_t      op_a;
    word_t      op_b;
    word_t      imm;

    assign opcode = fetch_inst[6:0];
    assign funct3 = fetch_inst[14:12];
    assign funct7 = fetch_inst[31:25];

    assign imm_i = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
    assign imm_u = {fetch_inst[31:12], 12'b0};
    assign imm_b = {{20{fetch_inst[31]}}, fetch_inst[7], fetch_inst[30:25],
                    fetch_inst[11:8], 1'b0};
    assign imm_j = {{12{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
                    fetch_inst[30:21], 1'b0};

    // Bit 4 of each index is checked for RV32E below.
    assign rs1_addr = fetch_inst[18:15];
    assign rs2_addr = fetch_inst[23:20];

    always_comb begin
        known     = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        uses_rd   = 1'b0;
        alu_op    = alu_add;
        ctrl_kind = ctrl_plain;
        op_a      = rs1_data;
        op_b      = rs2_data;
        imm       = imm_i;
        case (opcode)
            opc_op: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                uses_rd  = 1'b1;
                known    = funct7 == 7'b0000000 ||
                           (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            opc_op_imm: begin
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
                op_b     = imm_i;
                case (funct3)
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: alu_op = alu_add;
                endcase
                // No SLTIU in this subset.
                known = (funct3 == 3'b001) ? funct7 == 7'b0000000 :
                        (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                        funct3 != 3'b011;
            end
            opc_lui: begin
                known   = 1'b1;
                uses_rd = 1'b1;
                alu_op  = alu_pass_b;
                op_b    = imm_u;
                imm     = imm_u;
            end
            opc_auipc: begin
                known   = 1'b1;
                uses_rd = 1'b1;
                op_a    = fetch_pc;
                op_b    = imm_u;
                imm     = imm_u;
            end
            opc_branch: begin
                known     = funct3 inside {3'b000, 3'b001, 3'b100, 3'b101};
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                ctrl_kind = ctrl_branch;
                imm       = imm_b;
            end
            opc_jal: begin
                known     = 1'b1;
                uses_rd   = 1'b1;
                ctrl_kind = ctrl_jal;
                imm       = imm_j;
            end
            opc_jalr: begin
                known     = funct3 == 3'b000;
                uses_rs1  = 1'b1;
                uses_rd   = 1'b1;
                ctrl_kind = ctrl_jalr;
            end
            default: begin
                known = 1'b0;
            end
        endcase
        bad_reg = (uses_rs1 && fetch_inst[19]) ||
                  (uses_rs2 && fetch_inst[24]) ||
                  (uses_rd && fetch_inst[11]);
    end

    assign illegal = !known || bad_reg;

    assign decoded = '{
        pc:           fetch_pc,
        inst:         fetch_inst,
        operand_a:    op_a,
        operand_b:    op_b,
        rs1_value:    rs1_data,
        rs2_value:    rs2_data,
        imm:          imm,
        rd:           fetch_inst[10:7],
        rd_we:        uses_rd && !illegal,  // Illegal never writes.
        alu_op:       alu_op,
        ctrl_kind:    ctrl_kind,
        branch_funct: funct3,
        illegal:      illegal
    };

endmodule

// File: source/execute_unit.sv
module execute_unit (
    input  core_pkg::decoded_t decoded,
    output core_pkg::exec_t    executed
);
    import core_pkg::*;

    word_t      a;
    word_t      b;
    logic [4:0] shamt;
    word_t      alu_result;
    logic       branch_true;
    logic       taken;
    logic       is_jump;
    word_t      jalr_sum;
    word_t      target;

    assign a     = decoded.operand_a;
    assign b     = decoded.operand_b;
    assign shamt = b[4:0];

    always_comb begin
        case (decoded.alu_op)
            alu_add:  alu_result = a + b;
            alu_sub:  alu_result = a - b;
            alu_and:  alu_result = a & b;
            alu_or:   alu_result = a | b;
            alu_xor:  alu_result = a ^ b;
            alu_slt:  alu_result = word_t'($signed(a) < $signed(b));
            alu_sltu: alu_result = word_t'(a < b);
            alu_sll:  alu_result = a << shamt;
            alu_srl:  alu_result = a >> shamt;
            alu_sra:  alu_result = word_t'($signed(a) >>> shamt);
            default:  alu_result = b;
        endcase
    end

    // Compare uses the raw register values.
    always_comb begin
        case (decoded.branch_funct)
            3'b000:  branch_true = decoded.rs1_value == decoded.rs2_value;
            3'b001:  branch_true = decoded.rs1_value != decoded.rs2_value;
            3'b100:  branch_true = $signed(decoded.rs1_value) < $signed(decoded.rs2_value);
            3'b101:  branch_true = $signed(decoded.rs1_value) >= $signed(decoded.rs2_value);
            default: branch_true = 1'b0;
        endcase
    end

    assign is_jump = decoded.ctrl_kind == ctrl_jal || decoded.ctrl_kind == ctrl_jalr;
    assign taken   = ((decoded.ctrl_kind == ctrl_branch && branch_true) || is_jump) &&
                     !decoded.illegal;

    assign jalr_sum = decoded.rs1_value + decoded.imm;
    assign target   = (decoded.ctrl_kind == ctrl_jalr) ?
                      {jalr_sum[$bits(word_t)-1:1], 1'b0} : decoded.pc + decoded.imm;

    assign executed = '{
        pc:      decoded.pc,
        inst:    decoded.inst,
        result:  is_jump ? decoded.pc + word_t'(4) : alu_result,  // Link address.
        rd:      decoded.rd,
        rd_we:   decoded.rd_we,
        taken:   taken,
        target:  target,
        illegal: decoded.illegal
    };

endmodule

// File: source/result_unit.sv
module result_unit (
    input  logic              clock,
    input  logic              reset,
    input  logic              exec_valid,
    input  core_pkg::exec_t   executed,
    output logic              write_en,
    output logic [3:0]        write_addr,
    output logic [31:0]       write_data,
    output logic              redirect_valid,
    output logic [31:0]       redirect_pc,
    output logic              commit_valid,
    output core_pkg::commit_t commit
);
    import core_pkg::*;

    word_t next_pc;

    assign next_pc = executed.taken ? executed.target : executed.pc + word_t'(4);

    // Writes to x0 are dropped here.
    assign write_en   = exec_valid && executed.rd_we && !executed.illegal &&
                        executed.rd != '0;
    assign write_addr = executed.rd;
    assign write_data = executed.result;

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            commit_valid   <= exec_valid;
            redirect_valid <= exec_valid;  // Same cycle as commit.
        end
    end

    always_ff @(posedge clock) begin
        if (exec_valid) begin
            redirect_pc <= next_pc;
            commit      <= '{
                pc:       executed.pc,
                inst:     executed.inst,
                rd:       executed.rd,
                rd_we:    executed.rd_we,
                rd_value: executed.result,
                next_pc:  next_pc,
                illegal:  executed.illegal
            };
        end
    end

endmodule

// File: source/mini_core.sv
module mini_core (
    input  logic              clock,
    input  logic              reset,
    input  logic              inst_valid,
    input  logic [31:0]       inst_data,
    output logic              inst_req,
    output logic [31:0]       inst_addr,
    output logic              commit_valid,
    output core_pkg::commit_t commit
);
    import core_pkg::*;

    logic     fetch_valid;
    word_t    fetch_pc;
    word_t    fetch_inst;
    logic     redirect_valid;
    word_t    redirect_pc;
    reg_idx_t rs1_addr;
    reg_idx_t rs2_addr;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     write_en;
    reg_idx_t write_addr;
    word_t    write_data;
    decoded_t decoded;
    logic     dec_valid;
    decoded_t dec_q;
    exec_t    executed;
    logic     exec_valid;
    exec_t    exec_q;

    fetch_unit fetch_unit_inst (
        .clock          (clock),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst_data      (inst_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_inst     (fetch_inst)
    );

    register_file register_file_inst (
        .clock      (clock),
        .reset      (reset),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    decode_unit decode_unit_inst (
        .fetch_pc   (fetch_pc),
        .fetch_inst (fetch_inst),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .decoded    (decoded)
    );

    stage_reg #(.payload_t(decoded_t)) decode_stage_inst (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (fetch_valid),
        .in_data   (decoded),
        .out_valid (dec_valid),
        .out_data  (dec_q)
    );

    execute_unit execute_unit_inst (
        .decoded  (dec_q),
        .executed (executed)
    );

    stage_reg #(.payload_t(exec_t)) exec_stage_inst (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (dec_valid),
        .in_data   (executed),
        .out_valid (exec_valid),
        .out_data  (exec_q)
    );

    result_unit result_unit_inst (
        .clock          (clock),
        .reset          (reset),
        .exec_valid     (exec_valid),
        .executed       (exec_q),
        .write_en       (write_en),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .commit_valid   (commit_valid),
        .commit         (commit)
    );

endmodule

// File: tb/clock_gen.sv
module clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;  // 20 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        #2 reset = 1'b0;
    end

endmodule

// File: tb/mini_core_tb.sv
`include "core_cfg.svh"

module mini_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam int commits_to_run  = 2000;
    localparam int clock_period_ns = 20;
    localparam int timeout_ns      = commits_to_run * 10 * clock_period_ns +
                                     10 * clock_period_ns;

    logic    clock;
    logic    reset;
    logic    inst_valid;
    word_t   inst_data;
    logic    inst_req;
    word_t   inst_addr;
    logic    commit_valid;
    commit_t commit;

    word_t       imem [256];
    logic [31:0] lfsr_q = 32'h1d45;
    word_t       model_regs [`CORE_REG_COUNT] = '{default: '0};
    word_t       model_pc = `CORE_RESET_PC;
    int          valid_cycles [$];
    int          cycle_count = 0;
    int          commit_count = 0;
    int          req_expected_cycle = 2;  // One edge after reset is released.
    int          fetch_errors = 0;
    int          commit_errors = 0;
    int          timing_errors = 0;

    clock_gen clock_gen_inst (
        .clock (clock),
        .reset (reset)
    );

    mini_core mini_core_inst (
        .clock        (clock),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst_data    (inst_data),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] draw_bits(input int count);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q   = {lfsr_q[30:0], feedback};
            bits     = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    function automatic logic [4:0] pick_shamt();
        case (2'(draw_bits(2)))
            2'd0:    return 5'd0;
            2'd1:    return 5'd31;
            default: return 5'(draw_bits(5));
        endcase
    endfunction

    // Upper immediates near the signed boundary.
    function automatic logic [19:0] pick_upper();
        case (2'(draw_bits(2)))
            2'd0:    return 20'h80000;
            2'd1:    return 20'h7ffff;
            default: return 20'(draw_bits(20));
        endcase
    endfunction

    function automatic word_t make_instruction();
        logic [3:0]  kind;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] imm12;
        word_t       inst;
        kind   = 4'(draw_bits(4));
        rd     = 4'(draw_bits(4));
        rs1    = 4'(draw_bits(4));
        rs2    = 4'(draw_bits(4));
        funct3 = 3'(draw_bits(3));
        imm12  = 12'(draw_bits(12));
        funct7 = (draw_bits(1) == 32'd1 && (funct3 == 3'b000 || funct3 == 3'b101)) ?
                 7'h20 : 7'h00;
        case (kind)
            4'd0, 4'd1, 4'd2: begin
                inst = {funct7, 1'b0, rs2, 1'b0, rs1, funct3, 1'b0, rd, 7'b0110011};
            end
            4'd3, 4'd4, 4'd5, 4'd6, 4'd7: begin
                if (funct3 == 3'b011) begin
                    funct3 = 3'b010;
                end
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm12 = {(funct3 == 3'b101) ? funct7 : 7'h00, pick_shamt()};
                end
                inst = {imm12, 1'b0, rs1, funct3, 1'b0, rd, 7'b0010011};
            end
            4'd8, 4'd9: begin
                inst = {pick_upper(), 1'b0, rd, (kind == 4'd8) ? 7'b0110111 : 7'b0010111};
            end
            4'd10, 4'd11: begin
                funct3 = {1'(draw_bits(1)), 1'b0, 1'(draw_bits(1))};  // BEQ, BNE, BLT, BGE.
                inst   = {7'(draw_bits(7)), 1'b0, rs2, 1'b0, rs1, funct3,
                          5'(draw_bits(5)), 7'b1100011};
            end
            4'd12: inst = {20'(draw_bits(20)), 1'b0, rd, 7'b1101111};
            4'd13: inst = {imm12, 1'b0, rs1, 3'b000, 1'b0, rd, 7'b1100111};
            4'd14: begin
                inst = {7'h00, 1'b0, rs2, 1'b0, rs1, 2'b01, 1'(draw_bits(1)), 1'b0, rd,
                        7'b0110011};  // SLT or SLTU.
            end
            default: begin
                if (draw_bits(1) == 32'd1) begin
                    inst = {25'(draw_bits(25)), 7'b0000011};  // Load opcode.
                end else begin
                    inst = {funct7, 1'b0, rs2, 1'b0, rs1, funct3, 1'b1, rd, 7'b0110011};
                end
            end
        endcase
        return inst;
    endfunction

    function automatic word_t expected_alu(input logic [2:0] funct3, input logic alt,
                                           input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (funct3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << sh;
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Steps the architectural model by one instruction.
    function automatic commit_t reference_step(input word_t inst);
        commit_t    expected;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      value;
        word_t      next_pc;
        logic       legal;
        logic       writes;
        logic       taken;
        funct3  = inst[14:12];
        funct7  = inst[31:25];
        a       = model_regs[inst[18:15]];
        b       = model_regs[inst[23:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        value   = '0;
        next_pc = model_pc + 32'd4;
        legal   = 1'b0;
        writes  = 1'b0;
        case (inst[6:0])
            7'b0110011: begin
                legal  = funct7 == 7'h00 ||
                         (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
                legal  = legal && !inst[19] && !inst[24] && !inst[11];
                writes = 1'b1;
                value  = expected_alu(funct3, funct7[5], a, b);
            end
            7'b0010011: begin
                case (funct3)
                    3'b011:  legal = 1'b0;  // SLTIU.
                    3'b001:  legal = funct7 == 7'h00;
                    3'b101:  legal = funct7 == 7'h00 || funct7 == 7'h20;
                    default: legal = 1'b1;
                endcase
                legal  = legal && !inst[19] && !inst[11];
                writes = 1'b1;
                value  = expected_alu(funct3, funct3 == 3'b101 && funct7[5], a, imm_i);
            end
            7'b0110111, 7'b0010111: begin
                legal  = !inst[11];
                writes = 1'b1;
                value  = {inst[31:12], 12'b0};
                if (!inst[5]) begin
                    value = value + model_pc;  // AUIPC.
                end
            end
            7'b1100011: begin
                legal = (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b100 ||
                         funct3 == 3'b101) && !inst[19] && !inst[24];
                case (funct3)
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    3'b100:  taken = $signed(a) < $signed(b);
                    default: taken = $signed(a) >= $signed(b);
                endcase
                if (legal && taken) begin
                    next_pc = model_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                          inst[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                legal  = !inst[11];
                writes = 1'b1;
                value  = model_pc + 32'd4;
                if (legal) begin
                    next_pc = model_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                          inst[30:21], 1'b0};
                end
            end
            7'b1100111: begin
                legal  = funct3 == 3'b000 && !inst[19] && !inst[11];
                writes = 1'b1;
                value  = model_pc + 32'd4;
                if (legal) begin
                    next_pc = (a + imm_i) & ~32'd1;
                end
            end
            default: legal = 1'b0;
        endcase
        expected.pc       = model_pc;
        expected.inst     = inst;
        expected.rd       = inst[10:7];
        expected.rd_we    = writes && legal;
        expected.rd_value = value;
        expected.next_pc  = next_pc;
        expected.illegal  = !legal;
        if (expected.rd_we && inst[10:7] != 4'd0) begin
            model_regs[inst[10:7]] = value;
        end
        model_pc = next_pc;
        return expected;
    endfunction

    task automatic check_fetch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fetch_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_commit(input string name, input commit_t expected,
                                input commit_t actual);
        commit_t seen;
        seen = actual;
        if (!expected.rd_we) begin
            seen.rd_value = expected.rd_value;  // Not architectural without a write.
        end
        if (seen !== expected) begin
            commit_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_cycle(input string name, input int expected, input int actual);
        if (actual != expected) begin
            timing_errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic print_summary();
        $display("Commits %0d, fetch errors %0d, commit errors %0d, timing errors %0d",
                 commit_count, fetch_errors, commit_errors, timing_errors);
    endtask

    // Instruction memory with a reply latency of 1 to 4 cycles.
    initial begin
        int wait_cycles;
        inst_valid = 1'b0;
        inst_data  = '0;
        foreach (imem[i]) begin
            imem[i] = make_instruction();
        end
        forever begin
            @(posedge clock);
            #2;
            inst_valid = 1'b0;
            if (inst_req) begin
                wait_cycles = 1 + draw_bits(2);
                repeat (wait_cycles) @(posedge clock);
                #2;
                inst_data  = imem[inst_addr[9:2]];
                inst_valid = 1'b1;
            end
        end
    end

    // Outputs are stable at the falling edge.
    always @(negedge clock) begin
        commit_t expected;
        int      reply_cycle;
        if (!reset) begin
            cycle_count++;
            if (inst_valid) begin
                valid_cycles.push_back(cycle_count);
            end
            if (commit_valid) begin
                if (valid_cycles.size() == 0) begin
                    timing_errors++;
                    $display("Commit arrived without a reply from memory");
                end else begin
                    reply_cycle = valid_cycles.pop_front();
                    check_cycle("commit latency", 3, cycle_count - reply_cycle);
                end
                expected = reference_step(imem[model_pc[9:2]]);
                check_commit($sformatf("commit %0d", commit_count), expected, commit);
                req_expected_cycle = cycle_count + 1;
                commit_count++;
            end
            if (inst_req) begin
                if (req_expected_cycle < 0) begin
                    timing_errors++;
                    $display("Instruction request without a commit before it");
                end else begin
                    check_cycle("request cycle", req_expected_cycle, cycle_count);
                end
                check_fetch("fetch address", model_pc, inst_addr);
                req_expected_cycle = -1;
            end else if (cycle_count == req_expected_cycle) begin
                timing_errors++;
                $display("No instruction request in the cycle after a commit");
            end
        end
    end

    initial begin
        wait (commit_count == commits_to_run);
        print_summary();
        if (fetch_errors + commit_errors + timing_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the core stopped after %0d of %0d commits",
                 commit_count, commits_to_run);
        print_summary();
        $display("Errors found");
        $finish;
    end

endmodule

// File: mini_core.f
+incdir+source
source/core_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/stage_reg.sv
source/decode_unit.sv
source/execute_unit.sv
source/result_unit.sv
source/mini_core.sv
tb/clock_gen.sv
tb/mini_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f mini_core.f \
    --top-module mini_core_tb \
    --Mdir obj_dir \
    -o mini_core_sim

./obj_dir/mini_core_sim | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
